//--- rtl/dhcp_opt_pkg.sv
package dhcp_opt_pkg;

  ////////////////////////////////
  // Slot geometry
  ////////////////////////////////
  localparam int OPT_LEN        = 12;                       // Bytes per option slot
  localparam int OPT_NUM_TX     = 4;                        // Optional options
  localparam int OPT_SLOTS      = OPT_NUM_TX + 1;           // Plus the end slot
  localparam int OPT_TOT_LEN_TX = OPT_LEN * OPT_SLOTS;      // 60
  localparam int OPT_LEN_W      = $clog2(OPT_TOT_LEN_TX + 1);
  localparam int OPT_SLOT_W     = $clog2(OPT_SLOTS);

  ////////////////////////////////
  // Option codes and lengths
  ////////////////////////////////
  localparam logic [7:0] OPT_MSG_TYPE     = 8'd53;
  localparam logic [7:0] OPT_MSG_TYPE_LEN = 8'd1;
  localparam logic [7:0] OPT_REQ_IP       = 8'd50;
  localparam logic [7:0] OPT_REQ_IP_LEN   = 8'd4;
  localparam logic [7:0] OPT_CLI_ID       = 8'd61;
  localparam logic [7:0] OPT_CLI_ID_LEN   = 8'd7;  // Hardware type and MAC
  localparam logic [7:0] OPT_CLI_ID_HTYPE = 8'd1;  // Ethernet
  localparam logic [7:0] OPT_HOSTNAME     = 8'd12;
  localparam logic [7:0] OPT_HOSTNAME_LEN = 8'd8;
  localparam logic [7:0] OPT_PAD          = 8'd0;
  localparam logic [7:0] OPT_END          = 8'd255;

  localparam logic [0:7][7:0] HOSTNAME = "localnya";

  // DHCP message type carried in option 53
  typedef enum logic [7:0] {
    DISCOVER = 8'd1,
    REQUEST  = 8'd3,
    DECLINE  = 8'd4,
    RELEASE  = 8'd7
  } msg_type_t;

endpackage

//--- rtl/dhcp_hdr_pkg.sv
package dhcp_hdr_pkg;

  ////////////////////////////////
  // Lengths
  ////////////////////////////////
  localparam int HDR_LEN     = 240;  // Fixed header including cookie
  localparam int UDP_HDR_LEN = 8;
  localparam int UDP_LEN_W   = 16;
  localparam int PAY_MAX     = HDR_LEN + dhcp_opt_pkg::OPT_TOT_LEN_TX;
  localparam int IDX_W       = $clog2(PAY_MAX);  // 300 bytes need 9 bits

  localparam logic [31:0] MAGIC_COOKIE = 32'h63825363;

  // Constant header field values
  localparam logic [7:0] HDR_OP    = 8'd1;  // BOOTREQUEST
  localparam logic [7:0] HDR_HTYPE = 8'd1;
  localparam logic [7:0] HDR_HLEN  = 8'd6;
  localparam logic [7:0] HDR_HOPS  = 8'd0;

  ////////////////////////////////
  // Byte offsets in the payload
  ////////////////////////////////
  localparam logic [IDX_W-1:0] OFS_OP     = 'd0;
  localparam logic [IDX_W-1:0] OFS_HTYPE  = 'd1;
  localparam logic [IDX_W-1:0] OFS_HLEN   = 'd2;
  localparam logic [IDX_W-1:0] OFS_HOPS   = 'd3;
  localparam logic [IDX_W-1:0] OFS_XID    = 'd4;   // 4 bytes
  localparam logic [IDX_W-1:0] OFS_CIADDR = 'd12;  // 4 bytes
  localparam logic [IDX_W-1:0] OFS_CHADDR = 'd28;  // 6 bytes, zero up to 43
  localparam logic [IDX_W-1:0] OFS_COOKIE = 'd236;
  localparam logic [IDX_W-1:0] OFS_OPT    = IDX_W'(HDR_LEN);

  // Transmit sequencing
  typedef enum logic [1:0] {
    IDLE,
    ASSEMBLE,
    READY,
    STREAM
  } tx_state_t;

endpackage

//--- rtl/dhcp_opt_if.sv
`timescale 1ns/1ps

interface dhcp_opt_if;

  // Packed option slots, byte 0 goes out first
  logic [0:dhcp_opt_pkg::OPT_TOT_LEN_TX-1][7:0] opt_bytes;
  logic [dhcp_opt_pkg::OPT_LEN_W-1:0]           opt_len;   // Includes end slot
  logic                                         load;
  logic                                         done;

  modport assembler (
    input  load,
    output opt_bytes, opt_len, done
  );

  modport serializer (
    input opt_bytes, opt_len
  );

  modport fsm (
    input  done,
    output load
  );

endinterface

//--- rtl/dhcp_tx_fsm.sv
`timescale 1ns/1ps

module dhcp_tx_fsm (
  input  logic         clk,
  input  logic         fsm_rst,
  input  logic         start,
  input  logic         req,
  input  logic         last,
  dhcp_opt_if.fsm      opt,
  output logic         capture,
  output logic         cnt_inc,
  output logic         cnt_clr,
  output logic         rdy,
  output logic         streaming
);

  dhcp_hdr_pkg::tx_state_t state;
  logic                    fin;  // Last byte went out, leave next cycle

  ////////////////////////////////
  // Control outputs
  ////////////////////////////////
  assign capture   = start && (state == dhcp_hdr_pkg::IDLE);  // Start elsewhere ignored
  assign opt.load  = capture;
  assign rdy       = (state == dhcp_hdr_pkg::READY) || (state == dhcp_hdr_pkg::STREAM);
  assign streaming = (state == dhcp_hdr_pkg::STREAM);

  // One byte per requested cycle, nothing once the last byte has been sent
  assign cnt_inc = req && rdy && !fin;
  assign cnt_clr = capture || fin;

  ////////////////////////////////
  // State register
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= dhcp_hdr_pkg::IDLE;
      fin   <= 1'b0;
    end else begin
      fin <= cnt_inc && last;
      case (state)
        dhcp_hdr_pkg::IDLE: begin
          if (start) state <= dhcp_hdr_pkg::ASSEMBLE;
        end
        dhcp_hdr_pkg::ASSEMBLE: begin
          if (opt.done) state <= dhcp_hdr_pkg::READY;  // Options packed
        end
        dhcp_hdr_pkg::READY: begin
          if (cnt_inc) state <= dhcp_hdr_pkg::STREAM;
        end
        dhcp_hdr_pkg::STREAM: begin
          // Self reset one cycle after eof
          if (fin) state <= dhcp_hdr_pkg::IDLE;
        end
        default: state <= dhcp_hdr_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- rtl/dhcp_byte_counter.sv
`timescale 1ns/1ps

module dhcp_byte_counter (
  input  logic                                 clk,
  input  logic                                 fsm_rst,
  input  logic                                 clr,
  input  logic                                 inc,
  input  logic [dhcp_opt_pkg::OPT_LEN_W-1:0]   opt_len,
  output logic [dhcp_hdr_pkg::IDX_W-1:0]       idx,
  output logic                                 last
);

  logic [dhcp_hdr_pkg::IDX_W-1:0] last_idx;

  // Index of the END byte
  assign last_idx = dhcp_hdr_pkg::OFS_OPT + dhcp_hdr_pkg::IDX_W'(opt_len) - 1'b1;
  assign last     = (idx == last_idx);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      idx <= '0;
    end else if (clr) begin
      idx <= '0;
    end else if (inc) begin
      idx <= idx + 1'b1;
    end
  end

endmodule

//--- rtl/dhcp_opt_assembler.sv
`timescale 1ns/1ps

module dhcp_opt_assembler (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  dhcp_opt_pkg::msg_type_t msg_type,
  input  logic [31:0]             req_ip,
  input  logic [47:0]             client_mac,
  input  logic [3:0]              opt_pres,
  dhcp_opt_if.assembler           opt
);

  // Prototype slots in fixed order, end slot last
  logic [0:dhcp_opt_pkg::OPT_SLOTS-1][0:dhcp_opt_pkg::OPT_LEN-1][7:0] proto;
  logic [0:dhcp_opt_pkg::OPT_SLOTS-1][0:dhcp_opt_pkg::OPT_LEN-1][7:0] slots;
  logic [dhcp_opt_pkg::OPT_SLOTS-1:0]                                 pres;

  logic                                shifting;
  logic [dhcp_opt_pkg::OPT_SLOT_W-1:0] shift_cnt;
  logic [dhcp_opt_pkg::OPT_SLOT_W-1:0] slot_cnt;  // Slots appended so far

  assign opt.opt_bytes = slots;

  ////////////////////////////////
  // Control and length
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      shifting    <= 1'b0;
      shift_cnt   <= '0;
      slot_cnt    <= '0;
      opt.opt_len <= '0;
      opt.done    <= 1'b0;
    end else if (opt.load) begin
      shifting    <= 1'b1;
      shift_cnt   <= '0;
      slot_cnt    <= '0;
      opt.opt_len <= '0;
      opt.done    <= 1'b0;  // New message, restart
    end else if (shifting) begin
      shift_cnt <= shift_cnt + 1'b1;
      if (pres[0]) begin
        slot_cnt    <= slot_cnt + 1'b1;
        opt.opt_len <= opt.opt_len + dhcp_opt_pkg::OPT_LEN_W'(dhcp_opt_pkg::OPT_LEN);
      end
      // End slot is the final shift
      if (shift_cnt == dhcp_opt_pkg::OPT_SLOT_W'(dhcp_opt_pkg::OPT_NUM_TX)) begin
        shifting <= 1'b0;
        opt.done <= 1'b1;
      end
    end
  end

  ////////////////////////////////
  // Slot data
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (opt.load) begin
      proto <= {
        {dhcp_opt_pkg::OPT_MSG_TYPE, dhcp_opt_pkg::OPT_MSG_TYPE_LEN, msg_type,
         {(dhcp_opt_pkg::OPT_LEN - dhcp_opt_pkg::OPT_MSG_TYPE_LEN - 2){dhcp_opt_pkg::OPT_PAD}}},
        {dhcp_opt_pkg::OPT_REQ_IP, dhcp_opt_pkg::OPT_REQ_IP_LEN, req_ip,
         {(dhcp_opt_pkg::OPT_LEN - dhcp_opt_pkg::OPT_REQ_IP_LEN - 2){dhcp_opt_pkg::OPT_PAD}}},
        {dhcp_opt_pkg::OPT_CLI_ID, dhcp_opt_pkg::OPT_CLI_ID_LEN,
         dhcp_opt_pkg::OPT_CLI_ID_HTYPE, client_mac,
         {(dhcp_opt_pkg::OPT_LEN - dhcp_opt_pkg::OPT_CLI_ID_LEN - 2){dhcp_opt_pkg::OPT_PAD}}},
        {dhcp_opt_pkg::OPT_HOSTNAME, dhcp_opt_pkg::OPT_HOSTNAME_LEN, dhcp_opt_pkg::HOSTNAME,
         {(dhcp_opt_pkg::OPT_LEN - dhcp_opt_pkg::OPT_HOSTNAME_LEN - 2){dhcp_opt_pkg::OPT_PAD}}},
        {{(dhcp_opt_pkg::OPT_LEN - 1){dhcp_opt_pkg::OPT_PAD}}, dhcp_opt_pkg::OPT_END}
      };
      pres <= {1'b1, opt_pres};  // End slot always present
    end else if (shifting) begin
      proto[0:dhcp_opt_pkg::OPT_SLOTS-2] <= proto[1:dhcp_opt_pkg::OPT_SLOTS-1];
      pres <= pres >> 1;
      if (pres[0]) slots[slot_cnt] <= proto[0];  // Absent options leave no gap
    end
  end

endmodule

//--- rtl/dhcp_frame_serializer.sv
`timescale 1ns/1ps

module dhcp_frame_serializer (
  input  logic                                   clk,
  input  logic                                   fsm_rst,
  input  logic                                   capture,
  input  logic [31:0]                            xid,
  input  logic [31:0]                            ciaddr,
  input  logic [47:0]                            client_mac,
  input  logic [dhcp_hdr_pkg::IDX_W-1:0]         idx,
  input  logic                                   step,
  input  logic                                   first,
  input  logic                                   last,
  dhcp_opt_if.serializer                         opt,
  output logic [7:0]                             strm_dat,
  output logic                                   strm_val,
  output logic                                   strm_sof,
  output logic                                   strm_eof,
  output logic [dhcp_hdr_pkg::UDP_LEN_W-1:0]     udp_len
);

  logic [0:3][7:0] xid_q;
  logic [0:3][7:0] ciaddr_q;
  logic [0:5][7:0] mac_q;
  logic [0:3][7:0] cookie;

  logic [dhcp_hdr_pkg::IDX_W-1:0] rel_xid, rel_ci, rel_mac, rel_ck, rel_opt;
  logic [7:0]                     byte_sel;

  assign cookie = dhcp_hdr_pkg::MAGIC_COOKIE;

  assign udp_len = dhcp_hdr_pkg::UDP_LEN_W'(dhcp_hdr_pkg::HDR_LEN + dhcp_hdr_pkg::UDP_HDR_LEN)
                 + dhcp_hdr_pkg::UDP_LEN_W'(opt.opt_len);

  // Header fields held for the whole message
  always_ff @(posedge clk) begin
    if (capture) begin
      xid_q    <= xid;
      ciaddr_q <= ciaddr;
      mac_q    <= client_mac;
    end
  end

  ////////////////////////////////
  // Byte select
  ////////////////////////////////
  assign rel_xid = idx - dhcp_hdr_pkg::OFS_XID;
  assign rel_ci  = idx - dhcp_hdr_pkg::OFS_CIADDR;
  assign rel_mac = idx - dhcp_hdr_pkg::OFS_CHADDR;
  assign rel_ck  = idx - dhcp_hdr_pkg::OFS_COOKIE;
  assign rel_opt = idx - dhcp_hdr_pkg::OFS_OPT;

  always_comb begin
    byte_sel = 8'h00;  // Zero fields and chaddr padding
    if (idx >= dhcp_hdr_pkg::OFS_OPT) begin
      byte_sel = opt.opt_bytes[rel_opt[dhcp_opt_pkg::OPT_LEN_W-1:0]];
    end else if (idx == dhcp_hdr_pkg::OFS_OP) begin
      byte_sel = dhcp_hdr_pkg::HDR_OP;
    end else if (idx == dhcp_hdr_pkg::OFS_HTYPE) begin
      byte_sel = dhcp_hdr_pkg::HDR_HTYPE;
    end else if (idx == dhcp_hdr_pkg::OFS_HLEN) begin
      byte_sel = dhcp_hdr_pkg::HDR_HLEN;
    end else if (idx == dhcp_hdr_pkg::OFS_HOPS) begin
      byte_sel = dhcp_hdr_pkg::HDR_HOPS;
    end else if (rel_xid < 'd4) begin
      byte_sel = xid_q[rel_xid[1:0]];
    end else if (rel_ci < 'd4) begin
      byte_sel = ciaddr_q[rel_ci[1:0]];
    end else if (rel_mac < 'd6) begin
      byte_sel = mac_q[rel_mac[2:0]];
    end else if (rel_ck < 'd4) begin
      byte_sel = cookie[rel_ck[1:0]];  // Cookie closes the header
    end
  end

  ////////////////////////////////
  // Stream registers
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      strm_eof <= 1'b0;
    end else begin
      strm_val <= step;          // Low when req is held off
      strm_sof <= step && first;
      strm_eof <= step && last;
    end
  end

  always_ff @(posedge clk) begin
    if (step) strm_dat <= byte_sel;
  end

endmodule

//--- rtl/dhcp_tx_top.sv
`timescale 1ns/1ps

module dhcp_tx_top (
  input  logic                               clk,
  input  logic                               fsm_rst,
  input  logic                               start,
  input  dhcp_opt_pkg::msg_type_t            msg_type,
  input  logic [31:0]                        xid,
  input  logic [31:0]                        ciaddr,
  input  logic [31:0]                        req_ip,
  input  logic [47:0]                        client_mac,
  input  logic [3:0]                         opt_pres,
  input  logic                               req,
  output logic                               rdy,
  output logic [7:0]                         strm_dat,
  output logic                               strm_val,
  output logic                               strm_sof,
  output logic                               strm_eof,
  output logic [dhcp_hdr_pkg::UDP_LEN_W-1:0] udp_len
);

  logic                           capture;
  logic                           cnt_inc;
  logic                           cnt_clr;
  logic                           streaming;
  logic                           last;
  logic [dhcp_hdr_pkg::IDX_W-1:0] idx;

  dhcp_opt_if opt_if ();

  ////////////////////////////////
  // Control
  ////////////////////////////////
  dhcp_tx_fsm u_fsm (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .start     (start),
    .req       (req),
    .last      (last),
    .opt       (opt_if.fsm),
    .capture   (capture),
    .cnt_inc   (cnt_inc),
    .cnt_clr   (cnt_clr),
    .rdy       (rdy),
    .streaming (streaming)
  );

  dhcp_byte_counter u_cnt (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (cnt_clr),
    .inc     (cnt_inc),
    .opt_len (opt_if.opt_len),
    .idx     (idx),
    .last    (last)
  );

  ////////////////////////////////
  // Datapath
  ////////////////////////////////
  dhcp_opt_assembler u_asm (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .msg_type   (msg_type),
    .req_ip     (req_ip),
    .client_mac (client_mac),
    .opt_pres   (opt_pres),
    .opt        (opt_if.assembler)
  );

  // First byte is the step taken before STREAM is entered
  dhcp_frame_serializer u_ser (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .capture    (capture),
    .xid        (xid),
    .ciaddr     (ciaddr),
    .client_mac (client_mac),
    .idx        (idx),
    .step       (cnt_inc),
    .first      (!streaming),
    .last       (last),
    .opt        (opt_if.serializer),
    .strm_dat   (strm_dat),
    .strm_val   (strm_val),
    .strm_sof   (strm_sof),
    .strm_eof   (strm_eof),
    .udp_len    (udp_len)
  );

endmodule

//--- testbench/dhcp_tx_chk.sv
`timescale 1ns/1ps

module dhcp_tx_chk (
  input logic clk,
  input logic fsm_rst,
  input logic req,
  input logic rdy,
  input logic strm_val,
  input logic strm_sof,
  input logic strm_eof
);

  ////////////////////////////////
  // Stream protocol
  ////////////////////////////////
  sof_needs_val: assert property (@(posedge clk) disable iff (fsm_rst) strm_sof |-> strm_val)
    else $error("strm_sof high without strm_val");

  eof_needs_val: assert property (@(posedge clk) disable iff (fsm_rst) strm_eof |-> strm_val)
    else $error("strm_eof high without strm_val");

  // Every byte answers a request one cycle earlier
  val_follows_req: assert property (@(posedge clk) disable iff (fsm_rst) strm_val |-> $past(req))
    else $error("strm_val high without a request on the previous cycle");

  rdy_drops_after_eof: assert property (@(posedge clk) disable iff (fsm_rst) strm_eof |=> !rdy)
    else $error("rdy still high the cycle after strm_eof");

endmodule

bind dhcp_tx_top dhcp_tx_chk u_chk (
  .clk      (clk),
  .fsm_rst  (fsm_rst),
  .req      (req),
  .rdy      (rdy),
  .strm_val (strm_val),
  .strm_sof (strm_sof),
  .strm_eof (strm_eof)
);

//--- testbench/dhcp_tx_tb.sv
`timescale 1ns/1ps

module dhcp_tx_tb;

  localparam int RDY_TIMEOUT    = 50;
  localparam int STREAM_TIMEOUT = 2000;

  logic                    clk;
  logic                    fsm_rst;
  logic                    start;
  dhcp_opt_pkg::msg_type_t msg_type;
  logic [31:0]             xid;
  logic [31:0]             ciaddr;
  logic [31:0]             req_ip;
  logic [47:0]             client_mac;
  logic [3:0]              opt_pres;
  logic                    req;
  logic                    rdy;
  logic [7:0]              strm_dat;
  logic                    strm_val;
  logic                    strm_sof;
  logic                    strm_eof;
  logic [15:0]             udp_len;

  integer     seed;
  logic [7:0] model [0:299];  // Expected payload bytes
  int         model_len;

  dhcp_tx_top uut (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .start      (start),
    .msg_type   (msg_type),
    .xid        (xid),
    .ciaddr     (ciaddr),
    .req_ip     (req_ip),
    .client_mac (client_mac),
    .opt_pres   (opt_pres),
    .req        (req),
    .rdy        (rdy),
    .strm_dat   (strm_dat),
    .strm_val   (strm_val),
    .strm_sof   (strm_sof),
    .strm_eof   (strm_eof),
    .udp_len    (udp_len)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  ////////////////////////////////
  // Payload model
  ////////////////////////////////
  task automatic build_model(input logic [7:0] mtype, input logic [31:0] xid_v,
                             input logic [31:0] ci_v, input logic [31:0] ip_v,
                             input logic [47:0] mac_v, input logic [3:0] pres);
    int          pos;
    int          i;
    logic [63:0] host;
    logic [31:0] cookie;
    host   = "localnya";
    cookie = 32'h6382_5363;
    for (i = 0; i < 300; i++) model[i] = 8'h00;  // Zero fields and pad bytes
    model[0] = 8'h01;  // op
    model[1] = 8'h01;  // htype
    model[2] = 8'h06;  // hlen
    for (i = 0; i < 4; i++) begin
      model[4 + i]   = xid_v[31 - 8*i -: 8];
      model[12 + i]  = ci_v[31 - 8*i -: 8];
      model[236 + i] = cookie[31 - 8*i -: 8];
    end
    for (i = 0; i < 6; i++) model[28 + i] = mac_v[47 - 8*i -: 8];
    pos = 240;
    // Slots of 12 bytes in fixed order with no gap for absent options
    if (pres[0]) begin
      model[pos]     = 8'd53;
      model[pos + 1] = 8'd1;
      model[pos + 2] = mtype;
      pos += 12;
    end
    if (pres[1]) begin
      model[pos]     = 8'd50;
      model[pos + 1] = 8'd4;
      for (i = 0; i < 4; i++) model[pos + 2 + i] = ip_v[31 - 8*i -: 8];
      pos += 12;
    end
    if (pres[2]) begin
      model[pos]     = 8'd61;
      model[pos + 1] = 8'd7;
      model[pos + 2] = 8'd1;  // Ethernet
      for (i = 0; i < 6; i++) model[pos + 3 + i] = mac_v[47 - 8*i -: 8];
      pos += 12;
    end
    if (pres[3]) begin
      model[pos]     = 8'd12;
      model[pos + 1] = 8'd8;
      for (i = 0; i < 8; i++) model[pos + 2 + i] = host[63 - 8*i -: 8];
      pos += 12;
    end
    model[pos + 11] = 8'hff;  // END closes the end slot
    model_len       = pos + 12;
  endtask

  ////////////////////////////////
  // Stimulus and collection
  ////////////////////////////////
  task automatic launch_message(input dhcp_opt_pkg::msg_type_t mtype, input logic [31:0] xid_v,
                                input logic [31:0] ci_v, input logic [31:0] ip_v,
                                input logic [47:0] mac_v, input logic [3:0] pres);
    build_model(mtype, xid_v, ci_v, ip_v, mac_v, pres);
    @(posedge clk);
    start      <= 1'b1;
    msg_type   <= mtype;
    xid        <= xid_v;
    ciaddr     <= ci_v;
    req_ip     <= ip_v;
    client_mac <= mac_v;
    opt_pres   <= pres;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_ready();
    int cyc;
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!rdy && cyc < RDY_TIMEOUT);
    if (!rdy) begin
      $display("Timeout: rdy did not rise within %0d cycles of start", RDY_TIMEOUT);
      stop_with_failure();
    end else begin
      check_value("udp_len", udp_len, model_len + 8);
    end
  endtask

  task automatic stream_frame(input bit random_req, input int poke_cycle);
    int          n;
    int          cyc;
    bit          seen_eof;
    bit          req_d;  // Request driven this cycle
    bit          req_q;  // Request the DUT sampled for the byte seen now
    logic [31:0] rnd;
    n        = 0;
    cyc      = 0;
    seen_eof = 1'b0;
    req_q    = req;
    while (!seen_eof && cyc < STREAM_TIMEOUT) begin
      rnd   = next_random();
      req_d = random_req ? rnd[0] : 1'b1;
      @(posedge clk);
      req   <= req_d;
      start <= (cyc == poke_cycle);  // Stray start while streaming
      if (cyc == poke_cycle) begin
        xid      <= ~xid;
        opt_pres <= ~opt_pres;
      end
      @(negedge clk);
      check_value("strm_val", strm_val, req_q);  // One byte per requested cycle
      if (strm_val && n >= model_len) begin
        $display("Stream ran past the expected %0d bytes", model_len);
        stop_with_failure();
      end else if (strm_val) begin
        check_value($sformatf("strm_dat[%0d]", n), strm_dat, model[n]);
        check_value("strm_sof", strm_sof, n == 0);
        check_value("strm_eof", strm_eof, n == model_len - 1);
        check_value("udp_len", udp_len, model_len + 8);  // Stable while rdy
        seen_eof = strm_eof;
        n++;
      end
      req_q = req_d;
      cyc++;
    end
    if (!seen_eof) begin
      $display("Timeout: frame not finished, %0d of %0d bytes seen", n, model_len);
      stop_with_failure();
    end else begin
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      check_value("rdy", rdy, 1'b0);  // Self reset after eof
      check_value("strm_val", strm_val, 1'b0);
    end
  endtask

  ////////////////////////////////
  // Directed tests
  ////////////////////////////////
  task automatic discover_all_options();
    launch_message(dhcp_opt_pkg::DISCOVER, next_random(), 32'h0, 32'hc0a8_0164,
                   48'h0200_5e10_2233, 4'b1111);
    wait_ready();
    stream_frame(1'b0, -1);
  endtask

  task automatic request_two_options();
    launch_message(dhcp_opt_pkg::REQUEST, next_random(), 32'h0, 32'h0a00_0042,
                   48'h0200_5e10_2233, 4'b0011);
    wait_ready();
    stream_frame(1'b0, -1);
  endtask

  task automatic end_slot_only();
    launch_message(dhcp_opt_pkg::RELEASE, next_random(), 32'h0a00_0042, 32'h0,
                   48'h02aa_bbcc_ddee, 4'b0000);
    wait_ready();
    stream_frame(1'b0, -1);
  endtask

  task automatic random_back_pressure();
    launch_message(dhcp_opt_pkg::DECLINE, next_random(), 32'h0, 32'hac10_0a0b,
                   48'h02aa_bbcc_ddee, 4'b0111);
    wait_ready();
    stream_frame(1'b1, -1);  // req in a random pattern
  endtask

  task automatic stray_start_ignored();
    logic [31:0]             r0;
    logic [31:0]             r1;
    logic [31:0]             r2;
    dhcp_opt_pkg::msg_type_t mtype;
    launch_message(dhcp_opt_pkg::DISCOVER, next_random(), 32'h0, 32'hc0a8_0107,
                   48'h0200_5e10_4455, 4'b1111);
    wait_ready();
    stream_frame(1'b0, 40);
    r0 = next_random();
    r1 = next_random();
    r2 = next_random();
    case (r0[1:0])
      2'd0:    mtype = dhcp_opt_pkg::DISCOVER;
      2'd1:    mtype = dhcp_opt_pkg::REQUEST;
      2'd2:    mtype = dhcp_opt_pkg::DECLINE;
      default: mtype = dhcp_opt_pkg::RELEASE;
    endcase
    launch_message(mtype, r1, r2, next_random(), {r0[31:16], next_random()}, r0[7:4]);
    wait_ready();
    stream_frame(1'b0, -1);
  endtask

  initial begin
    seed       = 32'had88_ecfa;
    fsm_rst    <= 1'b1;
    start      <= 1'b0;
    msg_type   <= dhcp_opt_pkg::DISCOVER;
    xid        <= '0;
    ciaddr     <= '0;
    req_ip     <= '0;
    client_mac <= '0;
    opt_pres   <= '0;
    req        <= 1'b0;
    repeat (10) @(posedge clk);
    fsm_rst <= 1'b0;
    @(negedge clk);
    check_value("rdy", rdy, 1'b0);
    check_value("strm_val", strm_val, 1'b0);
    check_value("strm_sof", strm_sof, 1'b0);
    check_value("strm_eof", strm_eof, 1'b0);
    discover_all_options();
    request_two_options();
    end_slot_only();
    random_back_pressure();
    stray_start_ignored();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- tb.f
rtl/dhcp_opt_pkg.sv
rtl/dhcp_hdr_pkg.sv
rtl/dhcp_opt_if.sv
rtl/dhcp_tx_fsm.sv
rtl/dhcp_byte_counter.sv
rtl/dhcp_opt_assembler.sv
rtl/dhcp_frame_serializer.sv
rtl/dhcp_tx_top.sv
testbench/dhcp_tx_chk.sv
testbench/dhcp_tx_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the DHCP transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dhcp_tx_tb -f tb.f -o dhcp_tx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/dhcp_tx_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF "** PASS **"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
